//--- Makefile
TOP = routerOutputPort_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
src/nocPkg.sv
src/flitDecoder.sv
src/grantTimer.sv
src/portArbiter.sv
src/outputStage.sv
src/routerOutputPort.sv
tests/tbClock.sv
tests/routerOutputPort_properties.sv
tests/routerOutputPort_tb.sv

//--- src/flitDecoder.sv
module flitDecoder import nocPkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,
  input  flitId_t               inFlitId,
  input  logic [DATA_WIDTH-1:0] inData,
  input  logic                  accept,
  output logic                  req,
  output logic                  isHeader,
  output pktLen_t               hdrLength,
  output logic                  error
);

  logic inPacket;
  logic badFlit;

  assign req       = inValid;
  assign isHeader  = (inFlitId == FLIT_HEADER);
  assign hdrLength = isHeader ? inData[LEN_WIDTH-1:0] : '0;

  // framing check, only on flits that actually transfer.
  always_comb
  begin
    case (inFlitId)
      FLIT_HEADER: badFlit = inPacket || (hdrLength < pktLen_t'(2));
      FLIT_BODY:   badFlit = !inPacket;
      FLIT_TAIL:   badFlit = !inPacket;
      default:     badFlit = 1'b1; // unknown id.
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket <= 1'b0;
      error    <= 1'b0;
    end
    else if (accept)
    begin
      if (inFlitId == FLIT_HEADER)
        inPacket <= 1'b1;
      else if (inFlitId == FLIT_TAIL)
        inPacket <= 1'b0;
      if (badFlit)
        error <= 1'b1; // sticky.
    end
  end

endmodule

//--- src/grantTimer.sv
module grantTimer import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    load,
  input  pktLen_t length,
  input  logic    count,
  input  logic    run,
  output logic    done
);

  pktLen_t loadedLen;
  pktLen_t flitCount;

  // zero count never matches, so a fresh grant waits for its header.
  assign done = (flitCount == loadedLen) && (flitCount != '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      loadedLen <= '0;
      flitCount <= '0;
    end
    else
    begin
      if (load)
        loadedLen <= length;

      // also restart after done, in case the same port is granted again.
      if (!run || done)
        flitCount <= '0;
      else if (count)
        flitCount <= flitCount + 1'b1; // counts flits, not cycles.
    end
  end

endmodule

//--- src/nocPkg.sv
package nocPkg;

  // five router inputs, named L, N, E, W, S.
  localparam int NUM_PORTS = 5;

  // bit positions in every request, grant and accept vector.
  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  typedef logic [2:0] flitId_t;

  localparam flitId_t FLIT_HEADER = 3'b001;
  localparam flitId_t FLIT_BODY   = 3'b010;
  localparam flitId_t FLIT_TAIL   = 3'b100;

  // packet length in flits, header included.
  // It sits in the low 12 bits of the header data.
  typedef logic [11:0] pktLen_t;

  localparam int LEN_WIDTH = $bits(pktLen_t);

  // GRANT_x encodes as PORT_x + 1.
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    GRANT_L = 3'd1,
    GRANT_N = 3'd2,
    GRANT_E = 3'd3,
    GRANT_W = 3'd4,
    GRANT_S = 3'd5
  } arbState_t;

  function automatic arbState_t portState(input int port);
    return arbState_t'(port + 1);
  endfunction

endpackage

//--- src/outputStage.sv
module outputStage import nocPkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_PORTS-1:0]  grant,
  input  logic [NUM_PORTS-1:0]  inValid,
  input  flitId_t               inFlitId [NUM_PORTS],
  input  logic [DATA_WIDTH-1:0] inData [NUM_PORTS],
  output logic [NUM_PORTS-1:0]  inReady,
  output logic [NUM_PORTS-1:0]  accept,
  output logic                  outValid,
  output flitId_t               outFlitId,
  output logic [DATA_WIDTH-1:0] outData,
  input  logic                  outReady
);

  flitId_t               selFlitId;
  logic [DATA_WIDTH-1:0] selData;
  logic                  canLoad;
  logic                  anyAccept;

  // grant is one-hot or zero.
  always_comb
  begin
    selFlitId = '0;
    selData   = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        selFlitId = inFlitId[p];
        selData   = inData[p];
      end
    end
  end

  assign canLoad   = !outValid || outReady; // register empty or draining.
  assign inReady   = grant & {NUM_PORTS{canLoad}};
  assign accept    = inReady & inValid;
  assign anyAccept = |accept;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (anyAccept)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (anyAccept)
    begin
      outFlitId <= selFlitId;
      outData   <= selData;
    end
  end

endmodule

//--- src/portArbiter.sv
module portArbiter import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] req,
  input  logic [NUM_PORTS-1:0] hdrIsHeader,
  input  pktLen_t              hdrLength [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] accept,
  output logic [NUM_PORTS-1:0] grant
);

  arbState_t            state;
  arbState_t            nextState;
  logic [NUM_PORTS-1:0] inGrant;   // one-hot decode of state.
  logic [NUM_PORTS-1:0] timerDone;
  int                   curPort;

  // first requester from start onwards, wrapping around.
  function automatic arbState_t firstRequester(
    input logic [NUM_PORTS-1:0] reqs,
    input int                   start
  );
    arbState_t pick;
    int        idx;
    pick = IDLE;
    // walk backwards so the nearest requester wins.
    for (int i = NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = (start + i) % NUM_PORTS;
      if (reqs[idx])
        pick = portState(idx);
    end
    return pick;
  endfunction

  always_comb
  begin
    inGrant = '0;
    curPort = PORT_L;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (state == portState(p))
      begin
        inGrant[p] = 1'b1;
        curPort    = p;
      end
    end
  end

  // link closes in the cycle the timer reports the last flit.
  assign grant = inGrant & ~timerDone;

  always_comb
  begin
    nextState = state;
    if (state == IDLE)
      nextState = firstRequester(req, PORT_L);
    else if (inGrant == '0)
      nextState = IDLE; // unused encodings.
    else if (!req[curPort] || timerDone[curPort])
      nextState = firstRequester(req, (curPort + 1) % NUM_PORTS);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : genTimer
    grantTimer i_grantTimer
    (
      .clk    (clk),
      .rst    (rst),
      .load   (accept[p] & hdrIsHeader[p]),
      .length (hdrLength[p]),
      .count  (accept[p]),
      .run    (inGrant[p]),
      .done   (timerDone[p])
    );
  end

endmodule

//--- src/routerOutputPort.sv
module routerOutputPort import nocPkg::*;
#(
  parameter int DATA_WIDTH = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lValid,
  input  flitId_t               lFlitId,
  input  logic [DATA_WIDTH-1:0] lData,
  output logic                  lReady,
  input  logic                  nValid,
  input  flitId_t               nFlitId,
  input  logic [DATA_WIDTH-1:0] nData,
  output logic                  nReady,
  input  logic                  eValid,
  input  flitId_t               eFlitId,
  input  logic [DATA_WIDTH-1:0] eData,
  output logic                  eReady,
  input  logic                  wValid,
  input  flitId_t               wFlitId,
  input  logic [DATA_WIDTH-1:0] wData,
  output logic                  wReady,
  input  logic                  sValid,
  input  flitId_t               sFlitId,
  input  logic [DATA_WIDTH-1:0] sData,
  output logic                  sReady,
  output logic                  outValid,
  output flitId_t               outFlitId,
  output logic [DATA_WIDTH-1:0] outData,
  input  logic                  outReady,
  output logic                  protocolError
);

  logic [NUM_PORTS-1:0]  inValid;
  flitId_t               inFlitId [NUM_PORTS];
  logic [DATA_WIDTH-1:0] inData [NUM_PORTS];
  logic [NUM_PORTS-1:0]  inReady;
  logic [NUM_PORTS-1:0]  req;
  logic [NUM_PORTS-1:0]  isHeader;
  pktLen_t               hdrLength [NUM_PORTS];
  logic [NUM_PORTS-1:0]  accept;
  logic [NUM_PORTS-1:0]  grant;
  logic [NUM_PORTS-1:0]  decError;

  // gather the named inputs into port-indexed arrays.
  assign inValid[PORT_L]  = lValid;
  assign inValid[PORT_N]  = nValid;
  assign inValid[PORT_E]  = eValid;
  assign inValid[PORT_W]  = wValid;
  assign inValid[PORT_S]  = sValid;
  assign inFlitId[PORT_L] = lFlitId;
  assign inFlitId[PORT_N] = nFlitId;
  assign inFlitId[PORT_E] = eFlitId;
  assign inFlitId[PORT_W] = wFlitId;
  assign inFlitId[PORT_S] = sFlitId;
  assign inData[PORT_L]   = lData;
  assign inData[PORT_N]   = nData;
  assign inData[PORT_E]   = eData;
  assign inData[PORT_W]   = wData;
  assign inData[PORT_S]   = sData;
  assign lReady = inReady[PORT_L];
  assign nReady = inReady[PORT_N];
  assign eReady = inReady[PORT_E];
  assign wReady = inReady[PORT_W];
  assign sReady = inReady[PORT_S];

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : genDecoder
    flitDecoder #(.DATA_WIDTH(DATA_WIDTH)) i_flitDecoder
    (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inFlitId  (inFlitId[p]),
      .inData    (inData[p]),
      .accept    (accept[p]),
      .req       (req[p]),
      .isHeader  (isHeader[p]),
      .hdrLength (hdrLength[p]),
      .error     (decError[p])
    );
  end

  portArbiter i_portArbiter
  (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .hdrIsHeader (isHeader),
    .hdrLength   (hdrLength),
    .accept      (accept),
    .grant       (grant)
  );

  outputStage #(.DATA_WIDTH(DATA_WIDTH)) i_outputStage
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .inValid   (inValid),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .inReady   (inReady),
    .accept    (accept),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outReady  (outReady)
  );

  assign protocolError = |decError; // any input's framing fault.

endmodule

//--- tests/routerOutputPort_properties.sv
module routerOutputPort_properties import nocPkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input arbState_t            state,
  input logic [NUM_PORTS-1:0] grant,
  input logic [NUM_PORTS-1:0] accept
);

  int violations = 0; // summed into the testbench error count.

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    violations++;
    $error("grant %b is not one-hot", grant);
  end

  noGrantInIdle: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE) |-> (grant == '0))
  else
  begin
    violations++;
    $error("grant %b while arbiter is idle", grant);
  end

  // a transfer needs the link.
  acceptNeedsGrant: assert property (@(posedge clk) disable iff (rst)
    (accept & ~grant) == '0)
  else
  begin
    violations++;
    $error("accept %b without grant %b", accept, grant);
  end

endmodule

//--- tests/routerOutputPort_tb.sv
module routerOutputPort_tb import nocPkg::*;
();

  localparam int DATA_WIDTH  = 16;
  localparam int FLIT_W      = $bits(flitId_t) + DATA_WIDTH;
  localparam int MAX_CYCLES  = 4000; // tests take under 1500.
  localparam int DRAIN_LIMIT = 200;

  typedef logic [FLIT_W-1:0] flit_t;

  logic                  clk;
  logic                  rst;
  logic [NUM_PORTS-1:0]  valid;
  flitId_t               flitId [NUM_PORTS];
  logic [DATA_WIDTH-1:0] data [NUM_PORTS];
  logic [NUM_PORTS-1:0]  ready;
  logic                  outValid;
  flitId_t               outFlitId;
  logic [DATA_WIDTH-1:0] outData;
  logic                  outReady;
  logic                  protocolError;
  logic                  stallOn = 1'b0;

  flit_t  expQ [NUM_PORTS][$]; // per input, in send order.
  flit_t  outQ [$];
  integer seed = 32'h4f579259;
  int     errors = 0;
  int     tests = 0;
  int     cycles = 0;

  tbClock #(.PERIOD(40)) i_tbClock (.clk(clk));

  routerOutputPort #(.DATA_WIDTH(DATA_WIDTH)) i_routerOutputPort
  (
    .clk(clk),
    .rst(rst),
    .lValid(valid[PORT_L]), .lFlitId(flitId[PORT_L]), .lData(data[PORT_L]), .lReady(ready[PORT_L]),
    .nValid(valid[PORT_N]), .nFlitId(flitId[PORT_N]), .nData(data[PORT_N]), .nReady(ready[PORT_N]),
    .eValid(valid[PORT_E]), .eFlitId(flitId[PORT_E]), .eData(data[PORT_E]), .eReady(ready[PORT_E]),
    .wValid(valid[PORT_W]), .wFlitId(flitId[PORT_W]), .wData(data[PORT_W]), .wReady(ready[PORT_W]),
    .sValid(valid[PORT_S]), .sFlitId(flitId[PORT_S]), .sData(data[PORT_S]), .sReady(ready[PORT_S]),
    .outValid(outValid),
    .outFlitId(outFlitId),
    .outData(outData),
    .outReady(outReady),
    .protocolError(protocolError)
  );

  bind portArbiter routerOutputPort_properties i_props
  (
    .clk(clk),
    .rst(rst),
    .state(state),
    .grant(grant),
    .accept(accept)
  );

  always @(posedge clk)
  begin
    if (!rst && outValid && outReady)
      outQ.push_back({outFlitId, outData});
  end

  always @(negedge clk)
  begin
    if (stallOn)
      outReady = ($unsigned($random(seed)) % 4) != 0; // ready three cycles in four.
    else
      outReady = 1'b1;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // header data holds port and length, other flits port and a count.
  function automatic flit_t makeFlit(input int port, input int len, input int dataSeed,
                                     input int idx);
    flitId_t     id;
    logic [11:0] low;
    id  = (idx == 0) ? FLIT_HEADER : ((idx == len - 1) ? FLIT_TAIL : FLIT_BODY);
    low = (idx == 0) ? 12'(len) : 12'(dataSeed * 16 + idx);
    return {id, 1'b0, 3'(port), low};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp != act)
    begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic sendFlit(input int port, input flit_t flit);
    @(negedge clk);
    valid[port]  = 1'b1;
    flitId[port] = flit[FLIT_W-1 -: 3];
    data[port]   = flit[DATA_WIDTH-1:0];
    do
      @(posedge clk);
    while (!ready[port]);
  endtask

  task automatic sendPacket(input int port, input int len, input int dataSeed);
    flit_t flit;
    for (int i = 0; i < len; i++)
    begin
      flit = makeFlit(port, len, dataSeed, i);
      expQ[port].push_back(flit);
      sendFlit(port, flit);
    end
  endtask

  task automatic releasePort(input int port);
    @(negedge clk);
    valid[port] = 1'b0;
  endtask

  task automatic waitDrain(input string name);
    int expected;
    int waited;
    expected = 0;
    waited   = 0;
    for (int p = 0; p < NUM_PORTS; p++)
      expected += expQ[p].size();
    while ((outQ.size() < expected || outValid) && waited < DRAIN_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (outQ.size() < expected)
    begin
      $display("%s: output hung, %0d of %0d flits seen", name, outQ.size(), expected);
      errors++;
    end
  endtask

  // splits the output into packets and matches each against its input.
  task automatic checkPackets(input string name, input int order[$]);
    flit_t got;
    flit_t exp;
    int    port;
    int    len;
    int    seen[$];
    while (outQ.size() > 0)
    begin
      got  = outQ.pop_front();
      port = int'(got[LEN_WIDTH +: 3]);
      if (got[FLIT_W-1 -: 3] != FLIT_HEADER || port >= NUM_PORTS || expQ[port].size() == 0)
      begin
        $display("%s: output flit %h does not start a sent packet", name, got);
        errors++;
      end
      else
      begin
        seen.push_back(port);
        len = int'(got[LEN_WIDTH-1:0]);
        outQ.push_front(got);
        for (int i = 0; i < len; i++)
        begin
          if (outQ.size() == 0 || expQ[port].size() == 0)
          begin
            $display("%s: packet from port %0d cut short", name, port);
            errors++;
            break;
          end
          got = outQ.pop_front();
          exp = expQ[port].pop_front();
          checkValue(name, 32'(exp), 32'(got));
        end
      end
    end
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (expQ[p].size() != 0)
      begin
        $display("%s: %0d flits from port %0d never left", name, expQ[p].size(), p);
        errors++;
        expQ[p].delete();
      end
    end
    if (seen.size() != order.size())
    begin
      $display("%s: %0d packets left, %0d expected", name, seen.size(), order.size());
      errors++;
    end
    else
    begin
      for (int i = 0; i < order.size(); i++)
        checkValue({name, " source"}, order[i], seen[i]);
    end
  endtask

  task automatic endTest(input string name, input int errStart);
    tests++;
    if (errors == errStart)
      $display("test %s done, no errors", name);
    else
      $display("test %s done, %0d errors", name, errors - errStart);
  endtask

  task automatic testReset();
    int errStart;
    errStart = errors;
    checkValue("reset outValid", 0, outValid);
    checkValue("reset ready", 0, ready);
    checkValue("reset protocolError", 0, protocolError);
    endTest("reset", errStart);
  endtask

  task automatic testSinglePacket();
    int errStart;
    int order[$];
    errStart = errors;
    sendPacket(PORT_N, 4, 1);
    releasePort(PORT_N);
    waitDrain("singlePacket");
    order.push_back(PORT_N);
    checkPackets("singlePacket", order);
    checkValue("singlePacket protocolError", 0, protocolError);
    endTest("singlePacket", errStart);
  endtask

  task automatic testIdlePriority();
    int errStart;
    int order[$];
    errStart = errors;
    fork
      begin
        sendPacket(PORT_W, 3, 2);
        releasePort(PORT_W);
      end
      begin
        sendPacket(PORT_E, 4, 3);
        releasePort(PORT_E);
      end
    join
    waitDrain("idlePriority");
    order.push_back(PORT_E);
    order.push_back(PORT_W);
    checkPackets("idlePriority", order);
    endTest("idlePriority", errStart);
  endtask

  task automatic testRotation();
    int errStart;
    int order[$];
    errStart = errors;
    fork
      begin
        sendPacket(PORT_L, 3, 4);
        sendPacket(PORT_L, 2, 5); // header sits in the done cycle.
        releasePort(PORT_L);
      end
      begin
        sendPacket(PORT_N, 3, 6);
        releasePort(PORT_N);
      end
      begin
        sendPacket(PORT_S, 4, 7);
        releasePort(PORT_S);
      end
    join
    waitDrain("rotation");
    order = '{PORT_L, PORT_N, PORT_S, PORT_L};
    checkPackets("rotation", order);
    endTest("rotation", errStart);
  endtask

  task automatic testPacketBoundary();
    int errStart;
    int order[$];
    errStart = errors;
    sendPacket(PORT_L, 3, 8);
    sendPacket(PORT_L, 3, 9);
    sendPacket(PORT_L, 2, 10);
    releasePort(PORT_L);
    waitDrain("packetBoundary");
    order = '{PORT_L, PORT_L, PORT_L};
    checkPackets("packetBoundary", order);
    endTest("packetBoundary", errStart);
  endtask

  task automatic sendTwo(input int port, input int len);
    sendPacket(port, len, 20 + port);
    sendPacket(port, 7 - len, 30 + port);
    releasePort(port);
  endtask

  task automatic testBackPressure();
    int errStart;
    int lens [NUM_PORTS];
    int order[$];
    errStart = errors;
    for (int p = 0; p < NUM_PORTS; p++)
      lens[p] = 2 + int'($unsigned($random(seed)) % 4);
    stallOn = 1'b1;
    fork
      sendTwo(PORT_L, lens[PORT_L]);
      sendTwo(PORT_N, lens[PORT_N]);
      sendTwo(PORT_E, lens[PORT_E]);
      sendTwo(PORT_W, lens[PORT_W]);
      sendTwo(PORT_S, lens[PORT_S]);
    join
    waitDrain("backPressure");
    stallOn = 1'b0;
    // all five keep requesting, so the rotation goes round twice.
    order = '{PORT_L, PORT_N, PORT_E, PORT_W, PORT_S,
              PORT_L, PORT_N, PORT_E, PORT_W, PORT_S};
    checkPackets("backPressure", order);
    checkValue("backPressure protocolError", 0, protocolError);
    endTest("backPressure", errStart);
  endtask

  task automatic testFramingError();
    int errStart;
    int order[$];
    errStart = errors;
    sendFlit(PORT_S, makeFlit(PORT_S, 3, 40, 1)); // body with no header.
    releasePort(PORT_S);
    waitDrain("framingError");
    outQ.delete();
    checkValue("framingError flag", 1, protocolError);
    sendPacket(PORT_N, 3, 41);
    releasePort(PORT_N);
    waitDrain("framingError");
    order.push_back(PORT_N);
    checkPackets("framingError", order);
    checkValue("framingError sticky flag", 1, protocolError);
    endTest("framingError", errStart);
  endtask

  initial
  begin
    rst      = 1'b1;
    valid    = '0;
    outReady = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      flitId[p] = '0;
      data[p]   = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testReset();
    testSinglePacket();
    testIdlePriority();
    testRotation();
    testPacketBoundary();
    testBackPressure();
    testFramingError(); // last, the error flag is sticky.
    errors += i_routerOutputPort.i_portArbiter.i_props.violations;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- tests/tbClock.sv
module tbClock
#(
  parameter int PERIOD = 40
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD / 2);
      clk = ~clk;
    end
  end

endmodule
